//--- src/isaPkg.sv
/*
 * isaPkg
 * RV32I encoding subset used by the mini core datapath.
 * Opcode and funct constants, the instruction word with its
 * R, I and U format views, and the ALU function codes
 */
package isaPkg;

    // ------------------------------------------------------------------------
    // Major opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] OpReg   = 7'b0110011;
    localparam logic [6:0] OpImm   = 7'b0010011;
    localparam logic [6:0] OpLui   = 7'b0110111;
    localparam logic [6:0] OpAuipc = 7'b0010111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] Funct3AddSub = 3'b000;
    localparam logic [2:0] Funct3Sll    = 3'b001;
    localparam logic [2:0] Funct3Slt    = 3'b010;
    localparam logic [2:0] Funct3Xor    = 3'b100;
    localparam logic [2:0] Funct3Srl    = 3'b101;
    localparam logic [2:0] Funct3Or     = 3'b110;
    localparam logic [2:0] Funct3And    = 3'b111;

    // funct7, alternate form selects SUB
    localparam logic [6:0] Funct7Base = 7'b0000000;
    localparam logic [6:0] Funct7Alt  = 7'b0100000;

    // ------------------------------------------------------------------------
    // Instruction word, one 32 bit word seen three ways
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] Funct7;
        logic [4:0] Rs2;
        logic [4:0] Rs1;
        logic [2:0] Funct3;
        logic [4:0] Rd;
        logic [6:0] Opcode;
    } tInstR;

    typedef struct packed {
        logic [11:0] Imm12;
        logic [4:0]  Rs1;
        logic [2:0]  Funct3;
        logic [4:0]  Rd;
        logic [6:0]  Opcode;
    } tInstI;

    typedef struct packed {
        logic [19:0] Imm20;
        logic [4:0]  Rd;
        logic [6:0]  Opcode;
    } tInstU;

    typedef union packed {
        tInstR R;
        tInstI I;
        tInstU U;
    } tInst;

    // ALU functions
    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr  = 4'd3,
        AluXor = 4'd4,
        AluSlt = 4'd5,
        AluSll = 4'd6,
        AluSrl = 4'd7
    } tAluOp;

endpackage

//--- src/pipePkg.sv
/*
 * pipePkg
 * Bundles carried between the pipeline stages: register file
 * control, execute control, the result bundle and write port control
 */
package pipePkg;

    // ------------------------------------------------------------------------
    // Register file control
    // ------------------------------------------------------------------------
    // Sources come from Q101H decode, destination from Q105H write-back
    typedef struct packed {
        logic [1:0] Spare;
        logic [4:0] RegSrc1Q101H;
        logic [4:0] RegSrc2Q101H;
        logic [4:0] RegDstQ105H;
        logic       RegWrEnQ105H;
    } tCtrlRf;

    // ------------------------------------------------------------------------
    // Execute control, Q101H to Q102H
    // ------------------------------------------------------------------------
    typedef struct packed {
        isaPkg::tAluOp AluOp;
        // Operand 2 from the immediate
        logic          SelImm;
        // Operand 1 from the PC
        logic          SelPc;
        // Operand 1 forced to zero
        logic          Lui;
        logic [4:0]    RegDst;
        logic          RegWrEn;
    } tCtrlExe;

    // ------------------------------------------------------------------------
    // Result bundle, Q103H to Q105H
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic        Valid;
        logic        RegWrEn;
        logic [4:0]  RegDst;
        logic [31:0] Data;
    } tWbBundle;

    // Write port control, taken from the Q105H bundle
    typedef struct packed {
        logic [4:0] RegDst;
        logic       RegWrEn;
    } tCtrlWr;

endpackage

//--- src/instDecode.sv
/*
 * instDecode
 * Q101H decoder. Splits the instruction word into register sources,
 * execute controls and the immediate. Unsupported encodings and
 * empty slots leave the write enable clear
 */
`timescale 1ns/1ps

module instDecode (
    input  logic             InstValidQ101H,
    input  isaPkg::tInst     InstQ101H,
    output logic [4:0]       RegSrc1Q101H,
    output logic [4:0]       RegSrc2Q101H,
    output pipePkg::tCtrlExe CtrlExeQ101H,
    output logic [31:0]      ImmediateQ101H
);

    logic [6:0]  Opcode;
    logic [2:0]  Funct3;
    logic [6:0]  Funct7;
    logic [31:0] ImmI;
    logic [31:0] ImmU;
    logic        Known;

    // Field views
    assign Opcode = InstQ101H.R.Opcode;
    assign Funct3 = InstQ101H.R.Funct3;
    assign Funct7 = InstQ101H.R.Funct7;

    // Sign extended I immediate
    assign ImmI = {{20{InstQ101H.I.Imm12[11]}}, InstQ101H.I.Imm12};
    // U immediate sits in the upper 20 bits
    assign ImmU = {InstQ101H.U.Imm20, 12'b0};

    // ------------------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------------------
    always_comb begin
        Known          = 1'b0;
        RegSrc1Q101H   = 5'd0;
        RegSrc2Q101H   = 5'd0;
        ImmediateQ101H = 32'd0;
        CtrlExeQ101H   = '0;
        CtrlExeQ101H.AluOp  = isaPkg::AluAdd;
        CtrlExeQ101H.RegDst = InstQ101H.R.Rd;
        case (Opcode)
            isaPkg::OpReg: begin
                RegSrc1Q101H = InstQ101H.R.Rs1;
                RegSrc2Q101H = InstQ101H.R.Rs2;
                // Alternate funct7 is only legal for SUB here
                Known = (Funct7 == isaPkg::Funct7Base) ||
                        (Funct7 == isaPkg::Funct7Alt && Funct3 == isaPkg::Funct3AddSub);
                case (Funct3)
                    isaPkg::Funct3AddSub: begin
                        if (Funct7 == isaPkg::Funct7Alt) begin
                            CtrlExeQ101H.AluOp = isaPkg::AluSub;
                        end else begin
                            CtrlExeQ101H.AluOp = isaPkg::AluAdd;
                        end
                    end
                    isaPkg::Funct3Sll: CtrlExeQ101H.AluOp = isaPkg::AluSll;
                    isaPkg::Funct3Slt: CtrlExeQ101H.AluOp = isaPkg::AluSlt;
                    isaPkg::Funct3Xor: CtrlExeQ101H.AluOp = isaPkg::AluXor;
                    isaPkg::Funct3Srl: CtrlExeQ101H.AluOp = isaPkg::AluSrl;
                    isaPkg::Funct3Or:  CtrlExeQ101H.AluOp = isaPkg::AluOr;
                    isaPkg::Funct3And: CtrlExeQ101H.AluOp = isaPkg::AluAnd;
                    // SLTU not implemented
                    default: Known = 1'b0;
                endcase
            end
            isaPkg::OpImm: begin
                RegSrc1Q101H        = InstQ101H.I.Rs1;
                ImmediateQ101H      = ImmI;
                CtrlExeQ101H.SelImm = 1'b1;
                Known               = 1'b1;
                case (Funct3)
                    isaPkg::Funct3AddSub: CtrlExeQ101H.AluOp = isaPkg::AluAdd;
                    isaPkg::Funct3Slt:    CtrlExeQ101H.AluOp = isaPkg::AluSlt;
                    isaPkg::Funct3Xor:    CtrlExeQ101H.AluOp = isaPkg::AluXor;
                    isaPkg::Funct3Or:     CtrlExeQ101H.AluOp = isaPkg::AluOr;
                    isaPkg::Funct3And:    CtrlExeQ101H.AluOp = isaPkg::AluAnd;
                    // Immediate shifts and SLTIU are outside the subset
                    default: Known = 1'b0;
                endcase
            end
            isaPkg::OpLui: begin
                // Zero plus the U immediate
                ImmediateQ101H      = ImmU;
                CtrlExeQ101H.SelImm = 1'b1;
                CtrlExeQ101H.Lui    = 1'b1;
                Known               = 1'b1;
            end
            isaPkg::OpAuipc: begin
                // PC plus the U immediate
                ImmediateQ101H      = ImmU;
                CtrlExeQ101H.SelImm = 1'b1;
                CtrlExeQ101H.SelPc  = 1'b1;
                Known               = 1'b1;
            end
            default: Known = 1'b0;
        endcase
        // No write for empty slots or unknown encodings
        CtrlExeQ101H.RegWrEn = InstValidQ101H && Known;
    end

endmodule

//--- src/regFile.sv
/*
 * regFile
 * Integer register file. x0 reads as zero, Q105H write-back data is
 * forwarded to the Q101H read ports, and both operands together with
 * PC and immediate are registered into Q102H
 */
`timescale 1ns/1ps

module regFile #(
    parameter int RegNumMsb = 31
) (
    input  logic            Clock,
    input  logic            arstN,
    input  logic            Ready,
    input  pipePkg::tCtrlRf CtrlRf,
    input  logic [31:0]     PcQ101H,
    input  logic [31:0]     ImmediateQ101H,
    input  logic [31:0]     RegWrDataQ105H,
    output logic [31:0]     PcQ102H,
    output logic [31:0]     ImmediateQ102H,
    output logic [31:0]     RegRdData1Q102H,
    output logic [31:0]     RegRdData2Q102H
);

    // x0 is not stored
    logic [RegNumMsb:1][31:0] Register;
    logic                     RegWrEn;
    logic [31:0]              RegRdData1Q101H;
    logic [31:0]              RegRdData2Q101H;

    // ------------------------------------------------------------------------
    // Write port, Q105H
    // ------------------------------------------------------------------------
    // Held while stalled, destinations above RegNumMsb dropped
    assign RegWrEn = Ready && CtrlRf.RegWrEnQ105H && (CtrlRf.RegDstQ105H != 5'd0) &&
                     (CtrlRf.RegDstQ105H <= RegNumMsb);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            Register <= '0;
        end else if (RegWrEn) begin
            Register[CtrlRf.RegDstQ105H] <= RegWrDataQ105H;
        end
    end

    // ------------------------------------------------------------------------
    // Read ports, Q101H
    // ------------------------------------------------------------------------
    function automatic logic [31:0] readPort(input logic [4:0] Src);
        logic [31:0] Data;
        if (Src == 5'd0 || Src > RegNumMsb) begin
            Data = 32'd0;
        end else if (CtrlRf.RegWrEnQ105H && Src == CtrlRf.RegDstQ105H) begin
            // Bypass the write that lands this cycle
            Data = RegWrDataQ105H;
        end else begin
            Data = Register[Src];
        end
        return Data;
    endfunction

    // Re-evaluated on file contents and write-back data too
    always_comb begin
        RegRdData1Q101H = readPort(CtrlRf.RegSrc1Q101H);
        RegRdData2Q101H = readPort(CtrlRf.RegSrc2Q101H);
    end

    // Operand registers into Q102H
    always_ff @(posedge Clock) begin
        if (Ready) begin
            PcQ102H         <= PcQ101H;
            ImmediateQ102H  <= ImmediateQ101H;
            RegRdData1Q102H <= RegRdData1Q101H;
            RegRdData2Q102H <= RegRdData2Q101H;
        end
    end

endmodule

//--- src/aluExecute.sv
/*
 * aluExecute
 * Q102H execute stage. Picks both ALU operands, computes the result
 * and registers the write-back bundle into Q103H
 */
`timescale 1ns/1ps

module aluExecute (
    input  logic              Clock,
    input  logic              arstN,
    input  logic              Ready,
    input  pipePkg::tCtrlExe  CtrlExeQ101H,
    input  logic [31:0]       PcQ102H,
    input  logic [31:0]       ImmediateQ102H,
    input  logic [31:0]       RegRdData1Q102H,
    input  logic [31:0]       RegRdData2Q102H,
    output pipePkg::tWbBundle WbQ103H
);

    pipePkg::tCtrlExe CtrlExeQ102H;
    logic [31:0]      Operand1Q102H;
    logic [31:0]      Operand2Q102H;
    logic [31:0]      AluResultQ102H;

    // Execute control follows its operands into Q102H
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            CtrlExeQ102H <= '0;
        end else if (Ready) begin
            CtrlExeQ102H <= CtrlExeQ101H;
        end
    end

    // ------------------------------------------------------------------------
    // Operand select
    // ------------------------------------------------------------------------
    // LUI adds to zero, AUIPC to the PC
    assign Operand1Q102H = CtrlExeQ102H.Lui   ? 32'd0   :
                           CtrlExeQ102H.SelPc ? PcQ102H :
                                                RegRdData1Q102H;
    assign Operand2Q102H = CtrlExeQ102H.SelImm ? ImmediateQ102H : RegRdData2Q102H;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (CtrlExeQ102H.AluOp)
            isaPkg::AluAdd: AluResultQ102H = Operand1Q102H + Operand2Q102H;
            isaPkg::AluSub: AluResultQ102H = Operand1Q102H - Operand2Q102H;
            isaPkg::AluAnd: AluResultQ102H = Operand1Q102H & Operand2Q102H;
            isaPkg::AluOr:  AluResultQ102H = Operand1Q102H | Operand2Q102H;
            isaPkg::AluXor: AluResultQ102H = Operand1Q102H ^ Operand2Q102H;
            // Signed compare
            isaPkg::AluSlt: begin
                AluResultQ102H = {31'd0, $signed(Operand1Q102H) < $signed(Operand2Q102H)};
            end
            // Shift amount from the low 5 bits only
            isaPkg::AluSll: AluResultQ102H = Operand1Q102H << Operand2Q102H[4:0];
            isaPkg::AluSrl: AluResultQ102H = Operand1Q102H >> Operand2Q102H[4:0];
            default:        AluResultQ102H = 32'd0;
        endcase
    end

    // Result bundle into Q103H
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            WbQ103H <= '0;
        end else if (Ready) begin
            // Every supported instruction writes, so valid tracks the write enable
            WbQ103H.Valid   <= CtrlExeQ102H.RegWrEn;
            WbQ103H.RegWrEn <= CtrlExeQ102H.RegWrEn;
            WbQ103H.RegDst  <= CtrlExeQ102H.RegDst;
            WbQ103H.Data    <= AluResultQ102H;
        end
    end

endmodule

//--- src/wbPipe.sv
/*
 * wbPipe
 * Write-back pipe. Moves the result bundle from Q103H through Q104H
 * to Q105H and drives the register file write port
 */
`timescale 1ns/1ps

module wbPipe (
    input  logic              Clock,
    input  logic              arstN,
    input  logic              Ready,
    input  pipePkg::tWbBundle WbQ103H,
    output pipePkg::tWbBundle WbQ105H,
    output pipePkg::tCtrlWr   CtrlWrQ105H
);

    pipePkg::tWbBundle WbQ104H;

    // ------------------------------------------------------------------------
    // Bundle stages
    // ------------------------------------------------------------------------
    // Both stages freeze together when Ready is low
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            WbQ104H <= '0;
            WbQ105H <= '0;
        end else if (Ready) begin
            WbQ104H <= WbQ103H;
            WbQ105H <= WbQ104H;
        end
    end

    // ------------------------------------------------------------------------
    // Write port control
    // ------------------------------------------------------------------------
    assign CtrlWrQ105H.RegDst  = WbQ105H.RegDst;
    // An empty slot never writes
    assign CtrlWrQ105H.RegWrEn = WbQ105H.Valid && WbQ105H.RegWrEn;

endmodule

//--- src/miniCoreDatapath.sv
/*
 * miniCoreDatapath
 * Top of the five stage integer datapath, Q101H decode and register
 * read through Q105H write-back
 */
`timescale 1ns/1ps

module miniCoreDatapath #(
    parameter int RegNumMsb = 31
) (
    input  logic        Clock,
    input  logic        arstN,
    input  logic        Ready,
    input  logic        InstValidQ101H,
    input  logic [31:0] InstQ101H,
    input  logic [31:0] PcQ101H,
    output logic        WbValidQ105H,
    output logic [4:0]  WbDstQ105H,
    output logic [31:0] WbDataQ105H
);

    logic [4:0]        RegSrc1Q101H;
    logic [4:0]        RegSrc2Q101H;
    logic [31:0]       ImmediateQ101H;
    pipePkg::tCtrlExe  CtrlExeQ101H;
    pipePkg::tCtrlRf   CtrlRf;
    logic [31:0]       PcQ102H;
    logic [31:0]       ImmediateQ102H;
    logic [31:0]       RegRdData1Q102H;
    logic [31:0]       RegRdData2Q102H;
    pipePkg::tWbBundle WbQ103H;
    pipePkg::tWbBundle WbQ105H;
    pipePkg::tCtrlWr   CtrlWrQ105H;

    // Q101H decode
    instDecode instDecode_i (
        .InstValidQ101H (InstValidQ101H),
        .InstQ101H      (InstQ101H),
        .RegSrc1Q101H   (RegSrc1Q101H),
        .RegSrc2Q101H   (RegSrc2Q101H),
        .CtrlExeQ101H   (CtrlExeQ101H),
        .ImmediateQ101H (ImmediateQ101H)
    );

    // ------------------------------------------------------------------------
    // Register file control, read side from decode and write side from Q105H
    // ------------------------------------------------------------------------
    assign CtrlRf.Spare        = 2'b00;
    assign CtrlRf.RegSrc1Q101H = RegSrc1Q101H;
    assign CtrlRf.RegSrc2Q101H = RegSrc2Q101H;
    assign CtrlRf.RegDstQ105H  = CtrlWrQ105H.RegDst;
    assign CtrlRf.RegWrEnQ105H = CtrlWrQ105H.RegWrEn;

    regFile #(
        .RegNumMsb (RegNumMsb)
    ) regFile_i (
        .Clock           (Clock),
        .arstN           (arstN),
        .Ready           (Ready),
        .CtrlRf          (CtrlRf),
        .PcQ101H         (PcQ101H),
        .ImmediateQ101H  (ImmediateQ101H),
        .RegWrDataQ105H  (WbQ105H.Data),
        .PcQ102H         (PcQ102H),
        .ImmediateQ102H  (ImmediateQ102H),
        .RegRdData1Q102H (RegRdData1Q102H),
        .RegRdData2Q102H (RegRdData2Q102H)
    );

    // Q102H execute into Q103H
    aluExecute aluExecute_i (
        .Clock           (Clock),
        .arstN           (arstN),
        .Ready           (Ready),
        .CtrlExeQ101H    (CtrlExeQ101H),
        .PcQ102H         (PcQ102H),
        .ImmediateQ102H  (ImmediateQ102H),
        .RegRdData1Q102H (RegRdData1Q102H),
        .RegRdData2Q102H (RegRdData2Q102H),
        .WbQ103H         (WbQ103H)
    );

    // Q103H through Q105H
    wbPipe wbPipe_i (
        .Clock       (Clock),
        .arstN       (arstN),
        .Ready       (Ready),
        .WbQ103H     (WbQ103H),
        .WbQ105H     (WbQ105H),
        .CtrlWrQ105H (CtrlWrQ105H)
    );

    // Write-back observed at the top level
    assign WbValidQ105H = WbQ105H.Valid;
    assign WbDstQ105H   = WbQ105H.RegDst;
    assign WbDataQ105H  = WbQ105H.Data;

endmodule

//--- test/wbChecker.sv
/*
 * wbChecker
 * Watches the Q105H write-back ports and compares every result
 * with the next entry in its queue of expected writes
 */
`timescale 1ns/1ps

module wbChecker (
    input  logic        Clock,
    input  logic        arstN,
    input  logic        Ready,
    input  logic        WbValidQ105H,
    input  logic [4:0]  WbDstQ105H,
    input  logic [31:0] WbDataQ105H
);

    typedef struct packed {
        logic [4:0]  Dst;
        logic [31:0] Data;
    } tExpect;

    tExpect Expected[$];
    int     TestCount = 0;
    int     PassCount = 0;
    int     FailCount = 0;

    // Queued in issue order, results leave the pipe in the same order
    task automatic expectWrite(input logic [4:0] Dst, input logic [31:0] Data);
        tExpect Entry;
        Entry.Dst  = Dst;
        Entry.Data = Data;
        Expected.push_back(Entry);
    endtask

    // ------------------------------------------------------------------------
    // Compare on Ready-high edges
    // ------------------------------------------------------------------------
    // A bundle stays at Q105H for exactly one Ready-high edge
    always @(posedge Clock) begin
        tExpect Entry;
        logic   Good;
        if (arstN && Ready && WbValidQ105H) begin
            if (Expected.size() == 0) begin
                FailCount++;
                $display("error at %0t: write-back to x%0d while no result was expected",
                         $time, WbDstQ105H);
            end else begin
                Entry = Expected.pop_front();
                Good  = 1'b1;
                TestCount++;
                if (WbDstQ105H !== Entry.Dst) begin
                    Good = 1'b0;
                    $display("mismatch at %0t: WbDstQ105H expected %0d got %0d",
                             $time, Entry.Dst, WbDstQ105H);
                end
                if (WbDataQ105H !== Entry.Data) begin
                    Good = 1'b0;
                    $display("mismatch at %0t: WbDataQ105H expected 0x%08h got 0x%08h",
                             $time, Entry.Data, WbDataQ105H);
                end
                if (Good) begin
                    PassCount++;
                    $display("test %0d: x%0d = 0x%08h ok", TestCount, Entry.Dst, Entry.Data);
                end else begin
                    FailCount++;
                    $display("test %0d: x%0d failed", TestCount, Entry.Dst);
                end
            end
        end
    end

    // Anything still queued never reached Q105H
    task automatic finalReport(output int Passed, output int Failed);
        Failed = FailCount;
        foreach (Expected[i]) begin
            Failed++;
            $display("error: expected write-back x%0d = 0x%08h never appeared",
                     Expected[i].Dst, Expected[i].Data);
        end
        Passed = PassCount;
    endtask

endmodule

//--- test/miniCoreTb.sv
/*
 * miniCoreTb
 * Testbench for the mini core datapath. Runs a table of RV32I
 * instructions with stalls and empty slots through the DUT
 */
`timescale 1ns/1ps

module miniCoreTb;

    localparam int          ClockPeriod = 20;
    localparam int          DrainCycles = 6;
    localparam logic [31:0] PcBase      = 32'h0000_1000;

    // RV32I major opcodes
    localparam logic [6:0] OpcOp    = 7'b0110011;
    localparam logic [6:0] OpcOpImm = 7'b0010011;
    localparam logic [6:0] OpcLui   = 7'b0110111;
    localparam logic [6:0] OpcAuipc = 7'b0010111;
    localparam logic [6:0] OpcLoad  = 7'b0000011;

    // funct3 and funct7 fields
    localparam logic [2:0] F3Add      = 3'd0;
    localparam logic [2:0] F3Sll      = 3'd1;
    localparam logic [2:0] F3Slt      = 3'd2;
    localparam logic [2:0] F3Xor      = 3'd4;
    localparam logic [2:0] F3Srl      = 3'd5;
    localparam logic [2:0] F3Or       = 3'd6;
    localparam logic [2:0] F3And      = 3'd7;
    localparam logic [6:0] Funct7Base = 7'h00;
    localparam logic [6:0] Funct7Alt  = 7'h20;

    // One slot of the program
    typedef struct packed {
        logic [31:0] Inst;
        logic        Valid;
        logic [3:0]  Stall;
        logic        ExpWrite;
        logic [4:0]  ExpDst;
        logic [31:0] ExpData;
    } tRow;

    logic        Clock = 1'b0;
    logic        arstN;
    logic        Ready;
    logic        InstValidQ101H;
    logic [31:0] InstQ101H;
    logic [31:0] PcQ101H;
    logic        WbValidQ105H;
    logic [4:0]  WbDstQ105H;
    logic [31:0] WbDataQ105H;
    tRow         Rows[$];
    logic        TableReady = 1'b0;
    int          Passed;
    int          Failed;

    miniCoreDatapath #(
        .RegNumMsb (31)
    ) miniCoreDatapath_i (
        .Clock          (Clock),
        .arstN          (arstN),
        .Ready          (Ready),
        .InstValidQ101H (InstValidQ101H),
        .InstQ101H      (InstQ101H),
        .PcQ101H        (PcQ101H),
        .WbValidQ105H   (WbValidQ105H),
        .WbDstQ105H     (WbDstQ105H),
        .WbDataQ105H    (WbDataQ105H)
    );

    wbChecker wbChecker_i (
        .Clock        (Clock),
        .arstN        (arstN),
        .Ready        (Ready),
        .WbValidQ105H (WbValidQ105H),
        .WbDstQ105H   (WbDstQ105H),
        .WbDataQ105H  (WbDataQ105H)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    // ------------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rType(input logic [6:0] Funct7, input logic [4:0] Rs2,
                                          input logic [4:0] Rs1, input logic [2:0] Funct3,
                                          input logic [4:0] Rd);
        return {Funct7, Rs2, Rs1, Funct3, Rd, OpcOp};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] Opcode, input logic [11:0] Imm,
                                          input logic [4:0] Rs1, input logic [2:0] Funct3,
                                          input logic [4:0] Rd);
        return {Imm, Rs1, Funct3, Rd, Opcode};
    endfunction

    function automatic logic [31:0] uType(input logic [6:0] Opcode, input logic [19:0] Imm,
                                          input logic [4:0] Rd);
        return {Imm, Rd, Opcode};
    endfunction

    task automatic addRow(input logic [31:0] Inst, input logic Valid, input int Stall,
                          input logic ExpWrite, input logic [4:0] ExpDst,
                          input logic [31:0] ExpData);
        tRow Row;
        Row.Inst     = Inst;
        Row.Valid    = Valid;
        Row.Stall    = Stall[3:0];
        Row.ExpWrite = ExpWrite;
        Row.ExpDst   = ExpDst;
        Row.ExpData  = ExpData;
        Rows.push_back(Row);
    endtask

    // ------------------------------------------------------------------------
    // Program table, PC of slot i is PcBase + 4*i
    // ------------------------------------------------------------------------
    task automatic loadProgram();
        // Immediates, AUIPC sits at 0x100C
        addRow(iType(OpcOpImm, 12'h123, 5'd0, F3Add, 5'd1), 1'b1, 0, 1'b1, 5'd1, 32'h0000_0123);
        addRow(iType(OpcOpImm, 12'hFFB, 5'd0, F3Add, 5'd2), 1'b1, 0, 1'b1, 5'd2, 32'hFFFF_FFFB);
        addRow(uType(OpcLui, 20'h12345, 5'd3), 1'b1, 0, 1'b1, 5'd3, 32'h1234_5000);
        addRow(uType(OpcAuipc, 20'h00010, 5'd4), 1'b1, 0, 1'b1, 5'd4, 32'h0001_100C);
        addRow(iType(OpcOpImm, 12'h007, 5'd0, F3Add, 5'd5), 1'b1, 0, 1'b1, 5'd5, 32'h0000_0007);
        addRow(iType(OpcOpImm, 12'h7FF, 5'd0, F3Add, 5'd6), 1'b1, 0, 1'b1, 5'd6, 32'h0000_07FF);
        // Empty slot with a real word on the bus
        addRow(iType(OpcOpImm, 12'h001, 5'd0, F3Add, 5'd7), 1'b0, 0, 1'b0, 5'd0, 32'h0);
        // Register-register ops, SUB and AND take a source over the Q105H bypass
        addRow(rType(Funct7Base, 5'd2, 5'd1, F3Add, 5'd8), 1'b1, 0, 1'b1, 5'd8, 32'h0000_011E);
        addRow(rType(Funct7Alt, 5'd5, 5'd1, F3Add, 5'd9), 1'b1, 2, 1'b1, 5'd9, 32'h0000_011C);
        addRow(rType(Funct7Base, 5'd6, 5'd4, F3And, 5'd10), 1'b1, 0, 1'b1, 5'd10, 32'h0000_000C);
        addRow(rType(Funct7Base, 5'd1, 5'd3, F3Or, 5'd11), 1'b1, 0, 1'b1, 5'd11, 32'h1234_5123);
        addRow(rType(Funct7Base, 5'd6, 5'd2, F3Xor, 5'd12), 1'b1, 0, 1'b1, 5'd12, 32'hFFFF_F804);
        addRow(rType(Funct7Base, 5'd1, 5'd2, F3Slt, 5'd13), 1'b1, 1, 1'b1, 5'd13, 32'h0000_0001);
        addRow(rType(Funct7Base, 5'd2, 5'd1, F3Slt, 5'd14), 1'b1, 0, 1'b1, 5'd14, 32'h0000_0000);
        addRow(rType(Funct7Base, 5'd5, 5'd1, F3Sll, 5'd15), 1'b1, 0, 1'b1, 5'd15, 32'h0000_9180);
        addRow(rType(Funct7Base, 5'd5, 5'd2, F3Srl, 5'd16), 1'b1, 0, 1'b1, 5'd16, 32'h01FF_FFFF);
        // Shift by 0x7FF, only 31 counts
        addRow(rType(Funct7Base, 5'd6, 5'd5, F3Sll, 5'd17), 1'b1, 0, 1'b1, 5'd17, 32'h8000_0000);
        // Immediate ALU ops
        addRow(iType(OpcOpImm, 12'h0F0, 5'd11, F3And, 5'd18), 1'b1, 0, 1'b1, 5'd18, 32'h20);
        addRow(iType(OpcOpImm, 12'hF00, 5'd1, F3Or, 5'd19), 1'b1, 0, 1'b1, 5'd19, 32'hFFFF_FF23);
        addRow(iType(OpcOpImm, 12'hFFF, 5'd2, F3Xor, 5'd20), 1'b1, 0, 1'b1, 5'd20, 32'h0000_0004);
        addRow(iType(OpcOpImm, 12'hFFC, 5'd2, F3Slt, 5'd21), 1'b1, 0, 1'b1, 5'd21, 32'h0000_0001);
        addRow(iType(OpcOpImm, 12'h100, 5'd1, F3Slt, 5'd22), 1'b1, 0, 1'b1, 5'd22, 32'h0000_0000);
        // x0 write shows at the ports, never in the file
        addRow(iType(OpcOpImm, 12'h055, 5'd0, F3Add, 5'd0), 1'b1, 0, 1'b1, 5'd0, 32'h0000_0055);
        addRow(iType(OpcOpImm, 12'h001, 5'd0, F3Add, 5'd23), 1'b1, 0, 1'b1, 5'd23, 32'h1);
        // Empty slot, then a load the decoder rejects
        addRow(rType(Funct7Base, 5'd1, 5'd1, F3Add, 5'd25), 1'b0, 0, 1'b0, 5'd0, 32'h0);
        addRow(iType(OpcLoad, 12'h000, 5'd1, 3'd2, 5'd24), 1'b1, 0, 1'b0, 5'd0, 32'h0);
        // x0 read four slots after the x0 write
        addRow(rType(Funct7Base, 5'd0, 5'd0, F3Or, 5'd24), 1'b1, 3, 1'b1, 5'd24, 32'h0);
        // New x1, read two, three, four and five slots later
        addRow(iType(OpcOpImm, 12'h321, 5'd0, F3Add, 5'd1), 1'b1, 0, 1'b1, 5'd1, 32'h0000_0321);
        addRow(iType(OpcOpImm, 12'h010, 5'd0, F3Add, 5'd26), 1'b1, 0, 1'b1, 5'd26, 32'h10);
        addRow(rType(Funct7Base, 5'd0, 5'd1, F3Add, 5'd27), 1'b1, 0, 1'b1, 5'd27, 32'h0000_0123);
        addRow(iType(OpcOpImm, 12'h000, 5'd1, F3Add, 5'd28), 1'b1, 0, 1'b1, 5'd28, 32'h123);
        addRow(rType(Funct7Base, 5'd5, 5'd1, F3Add, 5'd29), 1'b1, 2, 1'b1, 5'd29, 32'h0000_0328);
        addRow(rType(Funct7Alt, 5'd26, 5'd1, F3Add, 5'd30), 1'b1, 0, 1'b1, 5'd30, 32'h0000_0311);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        arstN          = 1'b0;
        Ready          = 1'b0;
        InstValidQ101H = 1'b0;
        InstQ101H      = 32'd0;
        PcQ101H        = 32'd0;
        loadProgram();
        TableReady = 1'b1;
        repeat (2) @(posedge Clock);
        arstN <= 1'b1;
        Ready <= 1'b1;
        for (int i = 0; i < Rows.size(); i++) begin
            // Stall cycles hold the whole pipe
            repeat (Rows[i].Stall) begin
                @(posedge Clock);
                Ready          <= 1'b0;
                InstValidQ101H <= 1'b0;
            end
            @(posedge Clock);
            Ready          <= 1'b1;
            InstValidQ101H <= Rows[i].Valid;
            InstQ101H      <= Rows[i].Inst;
            PcQ101H        <= PcBase + 32'(4 * i);
            if (Rows[i].ExpWrite) begin
                wbChecker_i.expectWrite(Rows[i].ExpDst, Rows[i].ExpData);
            end
        end
        // Idle slots until the last result has left Q105H
        @(posedge Clock);
        Ready          <= 1'b1;
        InstValidQ101H <= 1'b0;
        repeat (DrainCycles) @(posedge Clock);
        wbChecker_i.finalReport(Passed, Failed);
        $display("tests passed: %0d, failed: %0d", Passed, Failed);
        if (Failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int StallTotal;
        int WatchCycles;
        wait (TableReady);
        StallTotal = 0;
        foreach (Rows[i]) begin
            StallTotal += int'(Rows[i].Stall);
        end
        WatchCycles = Rows.size() + StallTotal + 10;
        #(WatchCycles * ClockPeriod);
        $display("timeout: the run did not finish within %0d clock cycles", WatchCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- src.f
src/isaPkg.sv
src/pipePkg.sv
src/instDecode.sv
src/regFile.sv
src/aluExecute.sv
src/wbPipe.sv
src/miniCoreDatapath.sv
test/wbChecker.sv
test/miniCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the mini core testbench with Verilator and run it.
# The run passes only when the simulation prints its pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module miniCoreTb -f src.f \
    && ./obj_dir/VminiCoreTb | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
    && echo "run.sh: simulation run passed" \
    || { echo "run.sh: simulation run failed"; exit 1; }
